//--- build.f
+incdir+testbench
source/friscv_alu_pkg.sv
source/alu_decoder.sv
source/alu_arith.sv
source/alu_shifter.sv
source/rv32i_alu.sv
testbench/rv32i_alu_tb.sv

//--- testbench/alu_checks.svh
/*
 * ALU testbench compare tasks
 * typed value, address and bit checks with check and error counters
 */

`ifndef ALU_CHECKS_SVH
`define ALU_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_value(
    input string                 what,
    input friscv_alu_pkg::xlen_t expected,
    input friscv_alu_pkg::xlen_t actual
);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
    end
endtask

task automatic check_addr(
    input string                     what,
    input friscv_alu_pkg::reg_addr_t expected,
    input friscv_alu_pkg::reg_addr_t actual
);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail at %0t ns: %s expected %0d, got %0d", $time, what, expected, actual);
    end
endtask

task automatic check_bit(
    input string what,
    input logic  expected,
    input logic  actual
);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail at %0t ns: %s expected %b, got %b", $time, what, expected, actual);
    end
endtask

`endif

//--- testbench/rv32i_alu_tb.sv
/*
 * RV32I ALU testbench
 * directed register, immediate, shift, address and write-enable tests
 */

`timescale 1ns/1ps

module rv32i_alu_tb;

    localparam int HALF_PERIOD = 20;
    // cycles per test, for the watchdog
    localparam int N_RESET = 2;
    localparam int N_REG   = 10 * (25 + 200);
    localparam int N_IMM   = 6 * (30 + 20);
    localparam int N_SHIFT = 3 * 32 * 2;
    localparam int N_ADDR  = 50;
    localparam int N_WE    = 8;
    localparam int LIMIT   = N_RESET + N_REG + N_IMM + N_SHIFT + N_ADDR + N_WE + 50;

    logic                      aclk;
    logic                      reset = 1'b1;
    logic                      alu_en;
    friscv_alu_pkg::instr_t    instr;
    friscv_alu_pkg::reg_addr_t rs1_addr;
    friscv_alu_pkg::xlen_t     rs1_val;
    friscv_alu_pkg::reg_addr_t rs2_addr;
    friscv_alu_pkg::xlen_t     rs2_val;
    logic                      rd_wr;
    friscv_alu_pkg::reg_addr_t rd_addr;
    friscv_alu_pkg::xlen_t     rd_val;

    logic [31:0] lfsr_state = 32'ha0b;
    int          cycle_cnt  = 0;

    friscv_alu_pkg::xlen_t corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                           32'h7fff_ffff};
    logic [11:0]           imms [6]    = '{12'h000, 12'h001, 12'h005, 12'h7ff, 12'hfff, 12'h800};
    // register ops as funct3 and bit 30
    friscv_alu_pkg::funct3_t r_f3 [10] = '{
        friscv_alu_pkg::F3_ADD, friscv_alu_pkg::F3_ADD, friscv_alu_pkg::F3_SLT,
        friscv_alu_pkg::F3_SLTU, friscv_alu_pkg::F3_XOR, friscv_alu_pkg::F3_OR,
        friscv_alu_pkg::F3_AND, friscv_alu_pkg::F3_SLL, friscv_alu_pkg::F3_SR,
        friscv_alu_pkg::F3_SR};
    logic                    r_alt [10] = '{0, 1, 0, 0, 0, 0, 0, 0, 0, 1};
    friscv_alu_pkg::funct3_t i_f3 [6]   = '{
        friscv_alu_pkg::F3_ADD, friscv_alu_pkg::F3_SLT, friscv_alu_pkg::F3_SLTU,
        friscv_alu_pkg::F3_XOR, friscv_alu_pkg::F3_OR, friscv_alu_pkg::F3_AND};

    `include "alu_checks.svh"

    rv32i_alu u_rv32i_alu (
        .alu_en   (alu_en),
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val)
    );

    initial begin
        aclk = 1'b0;
        forever #(HALF_PERIOD) aclk = ~aclk;
    end

    // released on a falling edge after the reset cycles
    initial begin
        repeat (N_RESET) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
    end

    ////////////////////
    // stimulus helpers
    ////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic friscv_alu_pkg::instr_t r_type(input friscv_alu_pkg::funct3_t f3,
                                                      input logic alt);
        return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, friscv_alu_pkg::OPC_R_ARITH};
    endfunction

    function automatic friscv_alu_pkg::instr_t i_type(input friscv_alu_pkg::funct3_t f3,
                                                      input logic [11:0] imm);
        return {imm, 5'd5, f3, 5'd4, friscv_alu_pkg::OPC_I_ARITH};
    endfunction

    // expected rd_val straight from the RV32I rules
    function automatic friscv_alu_pkg::xlen_t model_result(input friscv_alu_pkg::instr_t ins,
        input friscv_alu_pkg::xlen_t a, input friscv_alu_pkg::xlen_t rs2);
        friscv_alu_pkg::xlen_t  b;
        friscv_alu_pkg::shamt_t sh;
        logic                   is_r;
        logic                   is_i;
        is_r = (ins[6:0] == friscv_alu_pkg::OPC_R_ARITH);
        is_i = (ins[6:0] == friscv_alu_pkg::OPC_I_ARITH);
        b    = is_i ? {{20{ins[31]}}, ins[31:20]} : rs2;
        sh   = b[4:0];
        if (!(is_r || is_i))
            return '0;
        case (ins[14:12])
            friscv_alu_pkg::F3_ADD:  return (is_r && ins[30]) ? a - b : a + b;
            friscv_alu_pkg::F3_SLL:  return a << sh;
            friscv_alu_pkg::F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            friscv_alu_pkg::F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            friscv_alu_pkg::F3_XOR:  return a ^ b;
            friscv_alu_pkg::F3_SR: begin
                if (ins[30])
                    return $signed(a) >>> sh;
                else
                    return a >> sh;
            end
            friscv_alu_pkg::F3_OR:   return a | b;
            default:                 return a & b;
        endcase
    endfunction

    // one vector per cycle, checked just before the next rising edge
    task automatic run_vector(input logic en, input friscv_alu_pkg::instr_t ins,
                              input friscv_alu_pkg::xlen_t a, input friscv_alu_pkg::xlen_t b);
        logic exp_wr;
        @(negedge aclk);
        alu_en  = en;
        instr   = ins;
        rs1_val = a;
        rs2_val = b;
        #(HALF_PERIOD - 1);
        exp_wr = en && (ins[6:0] == friscv_alu_pkg::OPC_R_ARITH ||
                        ins[6:0] == friscv_alu_pkg::OPC_I_ARITH);
        check_value("rd_val", model_result(ins, a, b), rd_val);
        check_bit("rd_wr", exp_wr, rd_wr);
        check_addr("rs1_addr", ins[19:15], rs1_addr);
        check_addr("rs2_addr", ins[24:20], rs2_addr);
        check_addr("rd_addr", ins[11:7], rd_addr);
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_register_ops();
        friscv_alu_pkg::xlen_t a;
        friscv_alu_pkg::xlen_t b;
        for (int op = 0; op < 10; op++) begin
            for (int i = 0; i < 5; i++)
                for (int j = 0; j < 5; j++)
                    run_vector(1'b1, r_type(r_f3[op], r_alt[op]), corners[i], corners[j]);
            repeat (200) begin
                a = lfsr_take(32);
                b = lfsr_take(32);
                run_vector(1'b1, r_type(r_f3[op], r_alt[op]), a, b);
            end
        end
    endtask

    // rs2_val is random and must not leak into the result
    task automatic test_immediate_ops();
        friscv_alu_pkg::xlen_t a;
        logic [11:0]           imm;
        for (int op = 0; op < 6; op++) begin
            for (int k = 0; k < 6; k++)
                for (int i = 0; i < 5; i++)
                    run_vector(1'b1, i_type(i_f3[op], imms[k]), corners[i], lfsr_take(32));
            repeat (20) begin
                imm = 12'(lfsr_take(12));
                a   = lfsr_take(32);
                run_vector(1'b1, i_type(i_f3[op], imm), a, lfsr_take(32));
            end
        end
    endtask

    task automatic test_shift_amounts();
        friscv_alu_pkg::xlen_t   a;
        friscv_alu_pkg::funct3_t f3;
        logic                    alt;
        for (int op = 0; op < 3; op++) begin
            f3  = (op == 0) ? friscv_alu_pkg::F3_SLL : friscv_alu_pkg::F3_SR;
            alt = (op == 2);
            for (int sh = 0; sh < 32; sh++) begin
                a     = lfsr_take(32);
                a[31] = sh[0];
                run_vector(1'b1, r_type(f3, alt), a, {27'h7ff_ffff, sh[4:0]});
                run_vector(1'b1, i_type(f3, {1'b0, alt, 5'b0, sh[4:0]}), a, lfsr_take(32));
            end
        end
    endtask

    task automatic test_register_addresses();
        friscv_alu_pkg::instr_t ins;
        logic [24:0]            fields;
        repeat (N_ADDR) begin
            fields = 25'(lfsr_take(25));
            ins    = {fields, friscv_alu_pkg::OPC_R_ARITH};
            run_vector(1'b1, ins, lfsr_take(32), lfsr_take(32));
        end
    endtask

    task automatic test_write_enable();
        run_vector(1'b0, r_type(friscv_alu_pkg::F3_ADD, 1'b0), 32'd7, 32'd9);
        run_vector(1'b0, i_type(friscv_alu_pkg::F3_OR, 12'h0f0), 32'h1234, 32'd0);
        // load, store and lui never write here
        run_vector(1'b1, 32'h0100_a183, 32'h55aa_55aa, 32'h1);
        run_vector(1'b1, 32'h0020_a223, 32'h1, 32'h2);
        run_vector(1'b1, 32'h1234_51b7, 32'h1, 32'h2);
        // addi with bit 30 set is still addi
        run_vector(1'b1, i_type(friscv_alu_pkg::F3_ADD, 12'h405), 32'h100, 32'd0);
        run_vector(1'b1, i_type(friscv_alu_pkg::F3_SLL, 12'h403), 32'h8000_0011, 32'd0);
        run_vector(1'b1, {7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011}, 32'd5, 32'd6);
    endtask

    ////////////////////
    // main flow
    ////////////////////

    initial begin : watchdog
        while (cycle_cnt < LIMIT) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("run timed out after %0d cycles", cycle_cnt);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        alu_en  = 1'b0;
        // arithmetic instruction, so only alu_en keeps rd_wr low
        instr   = r_type(friscv_alu_pkg::F3_ADD, 1'b0);
        rs1_val = '0;
        rs2_val = '0;
        while (reset) begin
            @(posedge aclk);
            check_bit("rd_wr during reset", 1'b0, rd_wr);
        end

        test_register_ops();
        test_immediate_ops();
        test_shift_amounts();
        test_register_addresses();
        test_write_enable();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- source/rv32i_alu.sv
/*
 * RV32I integer ALU, combinational
 * decodes R/I arithmetic instructions and returns the destination write
 */

`timescale 1ns/1ps

module rv32i_alu (
    // instruction
    input  logic                      alu_en,
    input  friscv_alu_pkg::instr_t    instr,
    // register file read ports
    output friscv_alu_pkg::reg_addr_t rs1_addr,
    input  friscv_alu_pkg::xlen_t     rs1_val,
    output friscv_alu_pkg::reg_addr_t rs2_addr,
    input  friscv_alu_pkg::xlen_t     rs2_val,
    // register file write port
    output logic                      rd_wr,
    output friscv_alu_pkg::reg_addr_t rd_addr,
    output friscv_alu_pkg::xlen_t     rd_val
);

    friscv_alu_pkg::alu_ctrl_t ctrl;
    friscv_alu_pkg::xlen_t     b;
    friscv_alu_pkg::xlen_t     arith_res;
    friscv_alu_pkg::xlen_t     shift_res;
    friscv_alu_pkg::xlen_t     logic_res;

    ////////////////////
    // decode
    ////////////////////

    alu_decoder u_alu_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign rs1_addr = ctrl.rs1_addr;
    assign rs2_addr = ctrl.rs2_addr;
    assign rd_addr  = ctrl.rd_addr;

    // write for any arithmetic opcode, even an unmatched funct
    assign rd_wr = alu_en & ctrl.arith_opc;

    // second operand
    assign b = ctrl.use_imm ? ctrl.imm : rs2_val;

    ////////////////////
    // units
    ////////////////////

    alu_arith u_alu_arith (
        .a   (rs1_val),
        .b   (b),
        .op  (ctrl.op),
        .res (arith_res)
    );

    // shamt is the low 5 bits of rs2 or of the immediate
    alu_shifter u_alu_shifter (
        .value (rs1_val),
        .shamt (b[friscv_alu_pkg::SHAMT_W-1:0]),
        .op    (ctrl.op),
        .res   (shift_res)
    );

    always_comb begin
        case (ctrl.op)
            friscv_alu_pkg::OP_XOR: logic_res = rs1_val ^ b;
            friscv_alu_pkg::OP_OR:  logic_res = rs1_val | b;
            friscv_alu_pkg::OP_AND: logic_res = rs1_val & b;
            default:                logic_res = '0;
        endcase
    end

    ////////////////////
    // result select
    ////////////////////

    always_comb begin
        case (ctrl.unit)
            friscv_alu_pkg::UNIT_ARITH: rd_val = arith_res;
            friscv_alu_pkg::UNIT_SHIFT: rd_val = shift_res;
            friscv_alu_pkg::UNIT_LOGIC: rd_val = logic_res;
            default:                    rd_val = '0;
        endcase
    end

endmodule

//--- source/alu_shifter.sv
/*
 * ALU barrel shifter
 * log shifter for sll, srl and sra, left shifts go through bit reversal
 */

`timescale 1ns/1ps

module alu_shifter (
    input  friscv_alu_pkg::xlen_t   value,
    input  friscv_alu_pkg::shamt_t  shamt,
    input  friscv_alu_pkg::alu_op_e op,
    output friscv_alu_pkg::xlen_t   res
);

    localparam int W = friscv_alu_pkg::XLEN;
    localparam int S = friscv_alu_pkg::SHAMT_W;

    logic                  is_left;
    logic                  is_shift;
    logic                  fill;
    friscv_alu_pkg::xlen_t stage [0:S];
    friscv_alu_pkg::xlen_t shifted;

    function automatic friscv_alu_pkg::xlen_t bit_rev(input friscv_alu_pkg::xlen_t v);
        friscv_alu_pkg::xlen_t r;
        for (int i = 0; i < W; i++) begin
            r[i] = v[W-1-i];
        end
        return r;
    endfunction

    assign is_left  = (op == friscv_alu_pkg::OP_SLL);
    assign is_shift = (op == friscv_alu_pkg::OP_SLL) ||
                      (op == friscv_alu_pkg::OP_SRL) ||
                      (op == friscv_alu_pkg::OP_SRA);

    // sign fill only for arithmetic right
    assign fill = (op == friscv_alu_pkg::OP_SRA) ? value[W-1] : 1'b0;

    ////////////////////
    // right shift stages
    ////////////////////

    assign stage[0] = is_left ? bit_rev(value) : value;

    // stage s shifts by 2**s
    for (genvar s = 0; s < S; s++) begin : g_stage
        localparam int STEP = 1 << s;
        assign stage[s+1] = shamt[s] ? {{STEP{fill}}, stage[s][W-1:STEP]} : stage[s];
    end

    assign shifted = is_left ? bit_rev(stage[S]) : stage[S];

    assign res = is_shift ? shifted : '0;

endmodule

//--- source/alu_arith.sv
/*
 * ALU arithmetic unit
 * add, sub and signed/unsigned set-less-than from one subtractor
 */

`timescale 1ns/1ps

module alu_arith (
    input  friscv_alu_pkg::xlen_t   a,
    input  friscv_alu_pkg::xlen_t   b,
    input  friscv_alu_pkg::alu_op_e op,
    output friscv_alu_pkg::xlen_t   res
);

    localparam int W = friscv_alu_pkg::XLEN;

    friscv_alu_pkg::xlen_t sum;
    logic [W:0]            sub_full;
    friscv_alu_pkg::xlen_t diff;
    logic                  carry;
    logic                  ovf;
    logic                  lt_s;
    logic                  lt_u;

    ////////////////////
    // adder
    ////////////////////

    assign sum = a + b;

    ////////////////////
    // subtractor
    ////////////////////

    // a + ~b + 1, carry out is the inverse of the borrow
    assign sub_full = {1'b0, a} + {1'b0, ~b} + (W+1)'(1);
    assign diff     = sub_full[W-1:0];
    assign carry    = sub_full[W];

    // operands of opposite sign and result sign differs from a
    assign ovf  = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

    assign lt_s = diff[W-1] ^ ovf;
    assign lt_u = ~carry;

    always_comb begin
        case (op)
            friscv_alu_pkg::OP_ADD:  res = sum;
            friscv_alu_pkg::OP_SUB:  res = diff;
            friscv_alu_pkg::OP_SLT:  res = friscv_alu_pkg::xlen_t'(lt_s);
            friscv_alu_pkg::OP_SLTU: res = friscv_alu_pkg::xlen_t'(lt_u);
            default:                 res = '0;
        endcase
    end

endmodule

//--- source/alu_decoder.sv
/*
 * ALU instruction decoder
 * splits an R/I arithmetic instruction into fields, picks operation and unit
 */

`timescale 1ns/1ps

module alu_decoder (
    input  friscv_alu_pkg::instr_t    instr,
    output friscv_alu_pkg::alu_ctrl_t ctrl
);

    friscv_alu_pkg::opcode_t   opcode;
    friscv_alu_pkg::funct3_t   funct3;
    logic                      alt;
    friscv_alu_pkg::reg_addr_t rs1;
    friscv_alu_pkg::reg_addr_t rs2;
    friscv_alu_pkg::reg_addr_t rd;
    friscv_alu_pkg::imm12_t    imm12;
    friscv_alu_pkg::xlen_t     imm_ext;

    logic                      is_r;
    logic                      is_i;
    friscv_alu_pkg::alu_op_e   op;
    friscv_alu_pkg::alu_unit_e unit;

    ////////////////////
    // fields
    ////////////////////

    assign opcode = instr[6:0];
    assign funct3 = instr[friscv_alu_pkg::F3_LSB +: 3];
    assign alt    = instr[friscv_alu_pkg::F7_ALT_BIT];
    assign rs1    = instr[friscv_alu_pkg::RS1_LSB +: friscv_alu_pkg::REG_ADDR_W];
    assign rs2    = instr[friscv_alu_pkg::RS2_LSB +: friscv_alu_pkg::REG_ADDR_W];
    assign rd     = instr[friscv_alu_pkg::RD_LSB +: friscv_alu_pkg::REG_ADDR_W];
    assign imm12  = instr[friscv_alu_pkg::IMM12_LSB +: friscv_alu_pkg::IMM12_W];

    assign imm_ext = {
        {(friscv_alu_pkg::XLEN - friscv_alu_pkg::IMM12_W){imm12[friscv_alu_pkg::IMM12_W-1]}},
        imm12
    };

    assign is_r = (opcode == friscv_alu_pkg::OPC_R_ARITH);
    assign is_i = (opcode == friscv_alu_pkg::OPC_I_ARITH);

    ////////////////////
    // operation
    ////////////////////

    always_comb begin
        op = friscv_alu_pkg::OP_NONE;
        if (is_r || is_i) begin
            case (funct3)
                // bit 30 is part of the immediate for addi
                friscv_alu_pkg::F3_ADD: begin
                    op = (is_r && alt) ? friscv_alu_pkg::OP_SUB : friscv_alu_pkg::OP_ADD;
                end
                friscv_alu_pkg::F3_SLL: begin
                    op = friscv_alu_pkg::OP_SLL;
                end
                friscv_alu_pkg::F3_SLT: begin
                    op = friscv_alu_pkg::OP_SLT;
                end
                friscv_alu_pkg::F3_SLTU: begin
                    op = friscv_alu_pkg::OP_SLTU;
                end
                friscv_alu_pkg::F3_XOR: begin
                    op = friscv_alu_pkg::OP_XOR;
                end
                friscv_alu_pkg::F3_SR: begin
                    op = alt ? friscv_alu_pkg::OP_SRA : friscv_alu_pkg::OP_SRL;
                end
                friscv_alu_pkg::F3_OR: begin
                    op = friscv_alu_pkg::OP_OR;
                end
                friscv_alu_pkg::F3_AND: begin
                    op = friscv_alu_pkg::OP_AND;
                end
                default: begin
                    op = friscv_alu_pkg::OP_NONE;
                end
            endcase
        end
    end

    // unit owning each operation
    always_comb begin
        case (op)
            friscv_alu_pkg::OP_ADD,
            friscv_alu_pkg::OP_SUB,
            friscv_alu_pkg::OP_SLT,
            friscv_alu_pkg::OP_SLTU: unit = friscv_alu_pkg::UNIT_ARITH;
            friscv_alu_pkg::OP_SLL,
            friscv_alu_pkg::OP_SRL,
            friscv_alu_pkg::OP_SRA:  unit = friscv_alu_pkg::UNIT_SHIFT;
            friscv_alu_pkg::OP_XOR,
            friscv_alu_pkg::OP_OR,
            friscv_alu_pkg::OP_AND:  unit = friscv_alu_pkg::UNIT_LOGIC;
            default:                 unit = friscv_alu_pkg::UNIT_NONE;
        endcase
    end

    assign ctrl = '{
        op:        op,
        unit:      unit,
        use_imm:   is_i,
        imm:       imm_ext,
        rs1_addr:  rs1,
        rs2_addr:  rs2,
        rd_addr:   rd,
        arith_opc: is_r || is_i
    };

endmodule

//--- source/friscv_alu_pkg.sv
/*
 * rv32i integer ALU package
 * widths, instruction encodings, operation enums and decoded control
 */

package friscv_alu_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int XLEN       = 32;
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int IMM12_W    = 12;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [IMM12_W-1:0]    imm12_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;

    ////////////////////
    // instruction fields
    ////////////////////

    // lsb position of each field in the instruction word
    localparam int RD_LSB     = 7;
    localparam int F3_LSB     = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int IMM12_LSB  = 20;

    // funct7[5], set for sub and sra
    localparam int F7_ALT_BIT = 30;

    localparam opcode_t OPC_R_ARITH = 7'b0110011;
    localparam opcode_t OPC_I_ARITH = 7'b0010011;

    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    ////////////////////
    // decoded control
    ////////////////////

    // immediate forms share the register-form operation
    typedef enum logic [3:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ARITH,
        UNIT_SHIFT,
        UNIT_LOGIC
    } alu_unit_e;

    typedef struct packed {
        alu_op_e   op;
        alu_unit_e unit;
        logic      use_imm;
        xlen_t     imm;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        logic      arith_opc;
    } alu_ctrl_t;

endpackage
